// File: verilog.f
hw/mem_pkg.sv
hw/load_ext.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/clint_timer.sv
hw/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - hw/mem_pkg.sv
  - hw/load_ext.sv
  - hw/mem_stage.sv
  - hw/data_ram.sv
  - hw/clint_timer.sv
  - hw/mem_subsys_top.sv
  - target: simulation
    files:
      - bench/tb_mem_subsys.sv

// File: bench/tb_mem_subsys.sv
module tb_mem_subsys import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAM_WORDS      = 256;
  localparam int RAM_LATENCY    = 3;
  localparam int TIMEOUT_CYCLES = 4000;   // ~200 accesses of 5 cycles, plus margin

  logic     clk;
  logic     rst;
  mem_op_e  mem_op;
  xlen_t    alu_result;
  xlen_t    store_data;
  reg_idx_t rd_idx;
  xlen_t    mem_result;
  reg_idx_t rd_idx_out;
  logic     stall;
  logic     timer_irq;

  logic [31:0] rng_state;
  logic [7:0]  ref_mem [RAM_WORDS*4];   // byte image of the data RAM
  int          err_count   = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          cycle_count = 0;

  mem_subsys_top #(.RAM_WORDS(RAM_WORDS), .RAM_LATENCY(RAM_LATENCY)) u_dut (
    .clk, .rst,
    .mem_op_i (mem_op), .alu_result_i (alu_result), .store_data_i (store_data),
    .rd_idx_i (rd_idx), .mem_result_o (mem_result), .rd_idx_o (rd_idx_out),
    .stall_o (stall), .timer_irq_o (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never released stall_o", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic void check_value(string tname, xlen_t exp, xlen_t got);
    check_count++;
    assert (got === exp) else begin
      $display("Mismatch in %s: expected %h, actual %h", tname, exp, got);
      err_count++;
    end
  endfunction

  function automatic void check_true(logic cond, string msg);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("%s", msg);
      err_count++;
    end
  endfunction

  function automatic int op_bytes(mem_op_e op);
    case (op)
      MEMOP_LB, MEMOP_LBU, MEMOP_SB: return 1;
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 2;
      default: return 4;
    endcase
  endfunction

  // first byte lane touched, word index wraps at the RAM depth
  function automatic int lane_of(xlen_t addr);
    return int'((addr >> 2) % RAM_WORDS) * 4 + int'(addr[1:0]);
  endfunction

  function automatic void model_store(mem_op_e op, xlen_t addr, xlen_t data);
    for (int i = 0; i < op_bytes(op); i++) begin
      ref_mem[lane_of(addr) + i] = data[8*i +: 8];
    end
  endfunction

  function automatic xlen_t model_load(mem_op_e op, xlen_t addr);
    xlen_t val;
    val = '0;
    for (int i = 0; i < op_bytes(op); i++) begin
      val[8*i +: 8] = ref_mem[lane_of(addr) + i];
    end
    if (op == MEMOP_LB && val[7]) val[31:8] = '1;     // sign fill
    if (op == MEMOP_LH && val[15]) val[31:16] = '1;
    return val;
  endfunction

  // called on a falling edge, returns on the falling edge of the ready cycle
  task automatic do_access(input mem_op_e op, input xlen_t addr, input xlen_t wdata,
                           output xlen_t result, output logic stalled);
    mem_op     = op;
    alu_result = addr;
    store_data = wdata;
    @(negedge clk);
    stalled = stall;
    while (stall) @(negedge clk);
    result = mem_result;
    mem_op = MEMOP_NONE;
  endtask

  task automatic store_op(mem_op_e op, xlen_t addr, xlen_t data);
    xlen_t res;
    logic  stalled;
    do_access(op, addr, data, res, stalled);
    model_store(op, addr, data);
  endtask

  task automatic load_and_check(string tname, mem_op_e op, xlen_t addr);
    xlen_t res;
    logic  stalled;
    do_access(op, addr, '0, res, stalled);
    check_value(tname, model_load(op, addr), res);
  endtask

  function automatic void report_test(string tname, int errs_before);
    test_count++;
    $display("test %-16s finished, %0d errors", tname, err_count - errs_before);
  endfunction

  task automatic test_pass_through();
    int       errs;
    xlen_t    val;
    reg_idx_t idx;
    errs = err_count;
    for (int i = 0; i < 8; i++) begin
      val        = next_rand();
      idx        = reg_idx_t'(next_rand());
      mem_op     = MEMOP_NONE;
      alu_result = val;
      rd_idx     = idx;
      @(negedge clk);
      check_value("pass_through", val, mem_result);
      check_value("pass_through", xlen_t'(idx), xlen_t'(rd_idx_out));
      check_true(stall === 1'b0, "pass_through: stall_o rose with no memory operation");
    end
    report_test("pass_through", errs);
  endtask

  task automatic test_word_round_trip();
    int    errs;
    xlen_t addr;
    xlen_t data;
    xlen_t res;
    logic  stalled;
    errs = err_count;
    for (int i = 0; i < 32; i++) begin
      addr = 32'h1000_0000 | (next_rand() & 32'h0000_03FC);
      data = next_rand();
      do_access(MEMOP_SW, addr, data, res, stalled);
      model_store(MEMOP_SW, addr, data);
      check_true(stalled, "word_round_trip: stall_o did not rise for a store");
      do_access(MEMOP_LW, addr, '0, res, stalled);
      check_true(stalled, "word_round_trip: stall_o did not rise for a load");
      check_value("word_round_trip", model_load(MEMOP_LW, addr), res);
    end
    report_test("word_round_trip", errs);
  endtask

  task automatic test_byte_half();
    int    errs;
    xlen_t addr;
    errs = err_count;
    for (int w = 0; w < 4; w++) begin
      addr = 32'h1000_0100 + 32'(w * 4);
      store_op(MEMOP_SW, addr, next_rand());
      for (int off = 0; off < 4; off++) store_op(MEMOP_SB, addr + off, next_rand());
      load_and_check("byte_half", MEMOP_LW, addr);
      store_op(MEMOP_SW, addr, next_rand());
      store_op(MEMOP_SH, addr, next_rand());
      store_op(MEMOP_SH, addr + 2, next_rand());
      load_and_check("byte_half", MEMOP_LW, addr);
    end
    report_test("byte_half", errs);
  endtask

  task automatic test_load_ext();
    int    errs;
    xlen_t addr;
    xlen_t pats [2];
    errs = err_count;
    pats = '{32'h80FF_9A85, 32'h7F01_357A};   // every byte negative, then positive
    for (int p = 0; p < 2; p++) begin
      addr = 32'h1000_0200 + 32'(p * 4);
      store_op(MEMOP_SW, addr, pats[p]);
      for (int off = 0; off < 4; off++) begin
        load_and_check("load_ext", MEMOP_LB, addr + off);
        load_and_check("load_ext", MEMOP_LBU, addr + off);
        if (off % 2 == 0) begin
          load_and_check("load_ext", MEMOP_LH, addr + off);
          load_and_check("load_ext", MEMOP_LHU, addr + off);
        end
      end
    end
    report_test("load_ext", errs);
  endtask

  // last test, its stores also land in RAM words 0 and 1
  task automatic test_timer();
    int    errs;
    xlen_t cmp_lo;
    xlen_t cmp_hi;
    xlen_t res;
    xlen_t first;
    logic  stalled;
    errs   = err_count;
    cmp_lo = next_rand();
    cmp_hi = next_rand();
    do_access(MEMOP_SW, MTIMECMP_ADDR_LO, cmp_lo, res, stalled);
    do_access(MEMOP_SW, MTIMECMP_ADDR_HI, cmp_hi, res, stalled);
    do_access(MEMOP_LW, MTIMECMP_ADDR_LO, '0, res, stalled);
    check_value("timer", cmp_lo, res);
    do_access(MEMOP_LW, MTIMECMP_ADDR_HI, '0, res, stalled);
    check_value("timer", cmp_hi, res);
    do_access(MEMOP_SW, MTIMECMP_ADDR_LO, '1, res, stalled);
    do_access(MEMOP_SW, MTIMECMP_ADDR_HI, '1, res, stalled);
    repeat (10) begin
      @(negedge clk);
      check_true(timer_irq === 1'b0, "timer: interrupt raised with mtimecmp at all ones");
    end
    do_access(MEMOP_SW, MTIMECMP_ADDR_HI, '0, res, stalled);
    do_access(MEMOP_SW, MTIMECMP_ADDR_LO, '0, res, stalled);
    for (int i = 0; i < 4 && timer_irq !== 1'b1; i++) @(negedge clk);
    check_true(timer_irq === 1'b1, "timer: interrupt did not rise with mtimecmp at zero");
    do_access(MEMOP_LW, MTIME_ADDR_LO, '0, first, stalled);
    repeat (5) @(negedge clk);
    do_access(MEMOP_LW, MTIME_ADDR_LO, '0, res, stalled);
    check_true(res > first, $sformatf("timer: mtime did not advance, %h then %h", first, res));
    report_test("timer", errs);
  endtask

  initial begin
    rng_state  = 32'h609e50d3;
    rst        = 1'b1;
    mem_op     = MEMOP_NONE;
    alu_result = '0;
    store_data = '0;
    rd_idx     = '0;
    foreach (ref_mem[i]) ref_mem[i] = 8'h00;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_pass_through();
    test_word_round_trip();
    test_byte_half();
    test_load_ext();
    test_timer();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: hw/mem_subsys_top.sv
module mem_subsys_top import mem_pkg::*; #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic     clk,
  input  logic     rst,
  input  mem_op_e  mem_op_i,
  input  xlen_t    alu_result_i,
  input  xlen_t    store_data_i,
  input  reg_idx_t rd_idx_i,
  output xlen_t    mem_result_o,
  output reg_idx_t rd_idx_o,
  output logic     stall_o,
  output logic     timer_irq_o
);

  // stage <-> data memory
  xlen_t      mem_addr;
  logic       mem_addr_valid;
  logic       mem_write;
  byte_mask_t mem_mask;
  xlen_t      mem_wdata;
  logic       mem_ready;
  xlen_t      mem_rdata;

  // stage <-> timer
  xlen_t      clint_addr;
  logic       clint_sel;
  logic       clint_write;
  xlen_t      clint_wdata;
  xlen_t      clint_rdata;

  mem_stage u_stage (
    .clk, .rst,
    .mem_op_i, .alu_result_i, .store_data_i, .rd_idx_i,
    .mem_result_o, .rd_idx_o, .stall_o,
    .mem_addr_o (mem_addr), .mem_addr_valid_o (mem_addr_valid),
    .mem_write_o (mem_write), .mem_mask_o (mem_mask),
    .mem_size_o (), .mem_wdata_o (mem_wdata),
    .mem_ready_i (mem_ready), .mem_rdata_i (mem_rdata),
    .clint_addr_o (clint_addr), .clint_sel_o (clint_sel),
    .clint_write_o (clint_write), .clint_wdata_o (clint_wdata),
    .clint_rdata_i (clint_rdata)
  );

  // ram works on whole words and byte lanes
  data_ram #(.RAM_WORDS(RAM_WORDS), .RAM_LATENCY(RAM_LATENCY)) u_ram (
    .clk, .rst,
    .addr_i (mem_addr), .addr_valid_i (mem_addr_valid), .write_i (mem_write),
    .mask_i (mem_mask), .wdata_i (mem_wdata),
    .ready_o (mem_ready), .rdata_o (mem_rdata)
  );

  clint_timer u_clint (
    .clk, .rst,
    .addr_i (clint_addr), .sel_i (clint_sel), .write_i (clint_write),
    .wdata_i (clint_wdata), .rdata_o (clint_rdata), .timer_irq_o
  );

endmodule

// File: hw/clint_timer.sv
module clint_timer import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  xlen_t addr_i,
  input  logic  sel_i,
  input  logic  write_i,
  input  xlen_t wdata_i,
  output xlen_t rdata_o,
  output logic  timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        wr_en;
  logic        wr_time_lo;
  logic        wr_time_hi;
  logic        wr_cmp_lo;
  logic        wr_cmp_hi;

  assign wr_en      = sel_i & write_i;
  assign wr_time_lo = wr_en & (addr_i == MTIME_ADDR_LO);
  assign wr_time_hi = wr_en & (addr_i == MTIME_ADDR_HI);
  assign wr_cmp_lo  = wr_en & (addr_i == MTIMECMP_ADDR_LO);
  assign wr_cmp_hi  = wr_en & (addr_i == MTIMECMP_ADDR_HI);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (wr_time_lo) begin
      mtime_q[31:0] <= wdata_i;    // count pauses while written
    end else if (wr_time_hi) begin
      mtime_q[63:32] <= wdata_i;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtimecmp_q <= '1;   // no interrupt out of reset
    end else begin
      if (wr_cmp_lo) mtimecmp_q[31:0] <= wdata_i;
      if (wr_cmp_hi) mtimecmp_q[63:32] <= wdata_i;
    end
  end

  always_comb begin
    case (addr_i)
      MTIME_ADDR_LO:    rdata_o = mtime_q[31:0];
      MTIME_ADDR_HI:    rdata_o = mtime_q[63:32];
      MTIMECMP_ADDR_LO: rdata_o = mtimecmp_q[31:0];
      MTIMECMP_ADDR_HI: rdata_o = mtimecmp_q[63:32];
      default:          rdata_o = '0;
    endcase
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// File: hw/data_ram.sv
module data_ram import mem_pkg::*; #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3    // at least 1
) (
  input  logic       clk,
  input  logic       rst,
  input  xlen_t      addr_i,
  input  logic       addr_valid_i,
  input  logic       write_i,
  input  byte_mask_t mask_i,
  input  xlen_t      wdata_i,
  output logic       ready_o,
  output xlen_t      rdata_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_RESP
  } ram_state_e;

  ram_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [IDX_W-1:0] idx_q;     // word captured at acceptance
  logic [IDX_W-1:0] req_idx;
  logic             accept;
  xlen_t            mem_q [RAM_WORDS];

  assign req_idx = IDX_W'((addr_i >> 2) % RAM_WORDS);
  assign accept  = (state_q == ST_IDLE) && addr_valid_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) begin
          state_q <= ST_BUSY;
          cnt_q   <= CNT_W'(RAM_LATENCY - 1);
          idx_q   <= req_idx;
        end
        ST_BUSY: begin
          if (cnt_q == '0) state_q <= ST_RESP;
          else cnt_q <= cnt_q - 1'b1;
        end
        default: state_q <= ST_IDLE;   // resp lasts one cycle
      endcase
    end
  end

  // byte lanes written at acceptance
  always_ff @(posedge clk) begin
    if (accept && write_i) begin
      for (int b = 0; b < 4; b++) begin
        if (mask_i[b]) mem_q[req_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  assign ready_o = (state_q == ST_RESP);
  assign rdata_o = mem_q[idx_q];

endmodule

// File: hw/mem_stage.sv
module mem_stage import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // from execute
  input  mem_op_e    mem_op_i,
  input  xlen_t      alu_result_i,   // address, or result of a non-memory op
  input  xlen_t      store_data_i,
  input  reg_idx_t   rd_idx_i,

  // to writeback
  output xlen_t      mem_result_o,
  output reg_idx_t   rd_idx_o,
  output logic       stall_o,

  // data memory
  output xlen_t      mem_addr_o,
  output logic       mem_addr_valid_o,
  output logic       mem_write_o,
  output byte_mask_t mem_mask_o,
  output size_code_t mem_size_o,
  output xlen_t      mem_wdata_o,
  input  logic       mem_ready_i,
  input  xlen_t      mem_rdata_i,

  // core-local timer
  output xlen_t      clint_addr_o,
  output logic       clint_sel_o,
  output logic       clint_write_o,
  output xlen_t      clint_wdata_o,
  input  xlen_t      clint_rdata_i
);

  logic       is_load;
  logic       is_store;
  logic       is_none;
  logic       ls_signed;
  size_code_t ls_size;
  byte_mask_t size_mask;
  xlen_t      addr;
  logic [1:0] offset;
  xlen_t      store_trim;
  xlen_t      rdata_sel;
  xlen_t      rdata_aligned;
  xlen_t      load_data;
  logic       write_sent;    // strobe already issued for this store

  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_none   = 1'b0;
    ls_signed = 1'b0;
    ls_size   = SIZE_NONE;
    case (mem_op_i)
      MEMOP_LB:  begin is_load = 1'b1; ls_signed = 1'b1; ls_size = SIZE_BYTE; end
      MEMOP_LBU: begin is_load = 1'b1; ls_size = SIZE_BYTE; end
      MEMOP_LH:  begin is_load = 1'b1; ls_signed = 1'b1; ls_size = SIZE_HALF; end
      MEMOP_LHU: begin is_load = 1'b1; ls_size = SIZE_HALF; end
      MEMOP_LW:  begin is_load = 1'b1; ls_signed = 1'b1; ls_size = SIZE_WORD; end
      MEMOP_SB:  begin is_store = 1'b1; ls_size = SIZE_BYTE; end
      MEMOP_SH:  begin is_store = 1'b1; ls_size = SIZE_HALF; end
      MEMOP_SW:  begin is_store = 1'b1; ls_size = SIZE_WORD; end
      default:   is_none = 1'b1;
    endcase
  end

  always_comb begin
    case (ls_size)
      SIZE_BYTE: size_mask = 4'b0001;
      SIZE_HALF: size_mask = 4'b0011;
      SIZE_WORD: size_mask = 4'b1111;
      default:   size_mask = 4'b0000;
    endcase
  end

  assign addr   = is_none ? IDLE_ADDR : alu_result_i;
  assign offset = addr[1:0];

  // store data cut down to the access size
  load_ext u_store_trim (
    .ext_data_i (store_data_i),
    .signed_i   (1'b0),
    .size_i     (ls_size),
    .ext_data_o (store_trim)
  );

  // data memory request, held until ready
  assign mem_addr_o       = addr;
  assign mem_addr_valid_o = (is_load | is_store) & ~mem_ready_i;
  assign mem_write_o      = is_store & mem_addr_valid_o & ~write_sent;
  assign mem_mask_o       = is_store ? byte_mask_t'(size_mask << offset) : size_mask;
  assign mem_size_o       = ls_size;
  assign mem_wdata_o      = store_trim << {offset, 3'b000};
  assign stall_o          = mem_addr_valid_o;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      write_sent <= 1'b0;
    end else if (mem_ready_i) begin
      write_sent <= 1'b0;   // access finished
    end else if (mem_write_o) begin
      write_sent <= 1'b1;
    end
  end

  // timer hits on any of its four word addresses
  assign clint_addr_o  = addr;
  assign clint_sel_o   = (addr == MTIME_ADDR_LO) | (addr == MTIME_ADDR_HI) |
                         (addr == MTIMECMP_ADDR_LO) | (addr == MTIMECMP_ADDR_HI);
  assign clint_write_o = is_store;
  assign clint_wdata_o = store_trim;

  assign rdata_sel     = clint_sel_o ? clint_rdata_i : (mem_ready_i ? mem_rdata_i : '0);
  assign rdata_aligned = rdata_sel >> {offset, 3'b000};

  load_ext u_load_ext (
    .ext_data_i (rdata_aligned),
    .signed_i   (ls_signed),
    .size_i     (ls_size),
    .ext_data_o (load_data)
  );

  always_comb begin
    if (is_load) mem_result_o = load_data;
    else if (is_none) mem_result_o = alu_result_i;
    else mem_result_o = '0;   // stores write nothing back
  end

  assign rd_idx_o = rd_idx_i;

endmodule

// File: hw/load_ext.sv
module load_ext import mem_pkg::*; (
  input  xlen_t      ext_data_i,
  input  logic       signed_i,   // 1 sign-extends, 0 zero-fills
  input  size_code_t size_i,
  output xlen_t      ext_data_o
);

  logic fill_bit;

  always_comb begin
    ext_data_o = ext_data_i;
    fill_bit   = 1'b0;
    case (size_i)
      SIZE_BYTE: begin
        fill_bit   = signed_i & ext_data_i[7];
        ext_data_o = {{24{fill_bit}}, ext_data_i[7:0]};
      end
      SIZE_HALF: begin
        fill_bit   = signed_i & ext_data_i[15];
        ext_data_o = {{16{fill_bit}}, ext_data_i[15:0]};
      end
      default: begin
        // full word, nothing to fill
        ext_data_o = ext_data_i;
      end
    endcase
  end

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

  typedef logic [31:0] xlen_t;      // data or address word
  typedef logic [4:0]  reg_idx_t;   // destination register
  typedef logic [3:0]  byte_mask_t; // one bit per byte lane

  // one-hot access size, bit 3 unused
  typedef logic [3:0]  size_code_t;

  localparam size_code_t SIZE_NONE = 4'b0000;
  localparam size_code_t SIZE_BYTE = 4'b0001;
  localparam size_code_t SIZE_HALF = 4'b0010;
  localparam size_code_t SIZE_WORD = 4'b0100;

  // load/store opcode from the execute stage
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } mem_op_e;

  // core-local timer register map
  localparam xlen_t MTIME_ADDR_LO    = 32'h0200_BFF8;
  localparam xlen_t MTIME_ADDR_HI    = 32'h0200_BFFC;
  localparam xlen_t MTIMECMP_ADDR_LO = 32'h0200_4000;
  localparam xlen_t MTIMECMP_ADDR_HI = 32'h0200_4004;

  // parked address when no access is in flight
  localparam xlen_t IDLE_ADDR = 32'h8000_0000;

endpackage
